// File: src.f
hdl/wdma_cfg_pkg.sv
hdl/wdma_intr_pkg.sv
hdl/wdma_cfg_decode.sv
hdl/wdma_intr_queue.sv
hdl/wdma_done_intr.sv
hdl/wdma_stall_counter.sv
hdl/wdma_intr_top.sv
verif/wdma_intr_assertions.sv
verif/wdma_intr_tb.sv

// File: Bender.yml
package:
  name: wdma_intr

sources:
  # rtl, packages first
  - files:
      - hdl/wdma_cfg_pkg.sv
      - hdl/wdma_intr_pkg.sv
      - hdl/wdma_cfg_decode.sv
      - hdl/wdma_intr_queue.sv
      - hdl/wdma_done_intr.sv
      - hdl/wdma_stall_counter.sv
      - hdl/wdma_intr_top.sv

  # verification
  - target: simulation
    files:
      - verif/wdma_intr_assertions.sv
      - verif/wdma_intr_tb.sv

// File: verif/wdma_intr_tb.sv
`timescale 1ns/1ps

module wdma_intr_tb;

  // ====================
  // run length
  // ====================

  localparam int unsigned DEPTH     = 4;
  localparam int unsigned SEED      = 22369;
  localparam int unsigned RESET_CYC = 8;
  localparam int unsigned NORM_SEG  = 100;
  localparam int unsigned NORM_SEGS = 4;
  localparam int unsigned BYP_SEG   = 50;
  localparam int unsigned FULL_CYC  = 150;
  localparam int unsigned QUIET_CYC = 150;
  localparam int unsigned STALL_CYC = 300;
  localparam int unsigned HOLD_CYC  = 200;
  // up to depth plus one idle cycle for each of the 11 drains
  localparam int unsigned DRAIN_CYC = 11 * (DEPTH + 1);
  localparam int unsigned TOTAL_CYC = RESET_CYC + NORM_SEGS * NORM_SEG + 2 * BYP_SEG
                                    + DEPTH + 20
                                    + FULL_CYC + 2 * QUIET_CYC + STALL_CYC + HOLD_CYC
                                    + DRAIN_CYC + 1;
  localparam int unsigned TIMEOUT_CYC = 2 * TOTAL_CYC;

  // dut inputs
  logic                      autosa_core_clk;
  logic                      autosa_core_rstn;
  logic                      dma_wr_req_vld_i;
  logic                      dma_wr_req_rdy_i;
  logic                      dma_wr_rsp_complete_i;
  logic                      intr_req_pvld_i;
  wdma_intr_pkg::intr_ptr_t  intr_req_ptr_i;
  logic                      op_load_i;
  wdma_cfg_pkg::alu_algo_t   reg2dp_ew_alu_algo_i;
  logic                      reg2dp_ew_alu_bypass_i;
  logic                      reg2dp_ew_bypass_i;
  logic                      reg2dp_op_en_i;
  logic                      reg2dp_output_dst_i;
  logic                      reg2dp_perf_dma_en_i;

  // dut outputs
  wdma_intr_pkg::stall_cnt_t dp2reg_wdma_stall_o;
  wdma_intr_pkg::intr_vec_t  sdp2glb_done_intr_pd_o;

  // reference model state
  wdma_intr_pkg::intr_ptr_t  model_q [$];
  wdma_intr_pkg::intr_vec_t  exp_intr;
  wdma_intr_pkg::stall_cnt_t exp_cnt;

  // 0 keeps both enables on and 1 turns at least one off
  int en_mode;
  // op_load drawn once in this many cycles
  int load_div;
  int err_cnt;
  int cycle_cnt = 0;
  int seed_val;

  wdma_intr_top DUT (
    .autosa_core_clk        (autosa_core_clk),
    .autosa_core_rstn       (autosa_core_rstn),
    .dma_wr_req_vld_i       (dma_wr_req_vld_i),
    .dma_wr_req_rdy_i       (dma_wr_req_rdy_i),
    .dma_wr_rsp_complete_i  (dma_wr_rsp_complete_i),
    .intr_req_pvld_i        (intr_req_pvld_i),
    .intr_req_ptr_i         (intr_req_ptr_i),
    .op_load_i              (op_load_i),
    .reg2dp_ew_alu_algo_i   (reg2dp_ew_alu_algo_i),
    .reg2dp_ew_alu_bypass_i (reg2dp_ew_alu_bypass_i),
    .reg2dp_ew_bypass_i     (reg2dp_ew_bypass_i),
    .reg2dp_op_en_i         (reg2dp_op_en_i),
    .reg2dp_output_dst_i    (reg2dp_output_dst_i),
    .reg2dp_perf_dma_en_i   (reg2dp_perf_dma_en_i),
    .dp2reg_wdma_stall_o    (dp2reg_wdma_stall_o),
    .sdp2glb_done_intr_pd_o (sdp2glb_done_intr_pd_o)
  );

  // 10 ns clock
  always #5 autosa_core_clk = ~autosa_core_clk;

  // hang guard
  always @(posedge autosa_core_clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= TIMEOUT_CYC) begin
      $display("timeout: stimulus did not finish within %0d cycles", TIMEOUT_CYC);
      $display("Test failed");
      $fatal(1, "simulation timeout");
    end
  end

  // ====================
  // helpers
  // ====================

  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    if (actual !== expected) begin
      err_cnt++;
      $display("[FAIL] %s expected 0x%08h actual 0x%08h", name, expected, actual);
      $display("Test failed");
      $fatal(1, "output mismatch");
    end
  endtask

  // quiet when equal runs unbypassed or output goes to pooling
  function automatic logic is_quiet();
    return (!reg2dp_ew_bypass_i && !reg2dp_ew_alu_bypass_i
            && reg2dp_ew_alu_algo_i == wdma_cfg_pkg::ALU_ALGO_EQL)
           || (reg2dp_output_dst_i == wdma_cfg_pkg::OUTPUT_DST_PDP);
  endfunction

  // random config that is never quiet
  task automatic set_normal_cfg();
    reg2dp_ew_alu_algo_i   = 2'($urandom % 4);
    reg2dp_ew_bypass_i     = 1'($urandom % 2);
    reg2dp_ew_alu_bypass_i = 1'($urandom % 2);
    reg2dp_output_dst_i    = 1'b0;
    // alu bypass keeps the equal code out of quiet mode
    if (!reg2dp_ew_bypass_i && reg2dp_ew_alu_algo_i == wdma_cfg_pkg::ALU_ALGO_EQL) begin
      reg2dp_ew_alu_bypass_i = 1'b1;
    end
  endtask

  // check the last prediction then drive and predict one cycle
  task automatic run_cycle(input logic req, input logic ptr, input logic cpl);
    logic [1:0]               en_draw;
    wdma_intr_pkg::intr_ptr_t head;
    @(negedge autosa_core_clk);
    check_value("sdp2glb_done_intr_pd_o", exp_intr, sdp2glb_done_intr_pd_o);
    check_value("dp2reg_wdma_stall_o", exp_cnt, dp2reg_wdma_stall_o);
    en_draw = (en_mode == 0) ? 2'b11 : 2'($urandom % 3);
    intr_req_pvld_i       = req;
    intr_req_ptr_i        = ptr;
    dma_wr_rsp_complete_i = cpl;
    dma_wr_req_vld_i      = 1'($urandom % 2);
    dma_wr_req_rdy_i      = 1'($urandom % 2);
    op_load_i             = ($urandom % load_div) == 0;
    reg2dp_op_en_i        = en_draw[0];
    reg2dp_perf_dma_en_i  = en_draw[1];
    // completion fires the oldest pending layer
    exp_intr = '0;
    if (cpl) begin
      head = model_q.pop_front();
      exp_intr[head] = 1'b1;
    end
    // a quiet request fires at once and a normal one waits
    if (req) begin
      if (is_quiet()) begin
        exp_intr[ptr] = 1'b1;
      end else begin
        model_q.push_back(ptr);
      end
    end
    // clear before increment and frozen when disabled
    if (reg2dp_op_en_i && reg2dp_perf_dma_en_i) begin
      if (op_load_i) begin
        exp_cnt = '0;
      end else if (dma_wr_req_vld_i && !dma_wr_req_rdy_i) begin
        exp_cnt = exp_cnt + 1'b1;
      end
    end
  endtask

  // random requests and completions with outstanding kept within depth
  task automatic run_random(input int cycles, input int req_pct, input int cpl_pct);
    logic cpl;
    logic req;
    repeat (cycles) begin
      cpl = (model_q.size() > 0) && (($urandom % 100) < cpl_pct);
      req = ((model_q.size() - int'(cpl)) < DEPTH) && (($urandom % 100) < req_pct);
      run_cycle(req, 1'($urandom % 2), cpl);
    end
  endtask

  // empty the queue with no new requests
  task automatic drain();
    do begin
      run_cycle(1'b0, 1'b0, model_q.size() > 0);
    end while (model_q.size() > 0);
  endtask

  // ====================
  // main sequence
  // ====================

  initial begin
    seed_val               = $urandom(SEED);
    autosa_core_clk        = 1'b0;
    autosa_core_rstn       = 1'b0;
    dma_wr_req_vld_i       = 1'b0;
    dma_wr_req_rdy_i       = 1'b0;
    dma_wr_rsp_complete_i  = 1'b0;
    intr_req_pvld_i        = 1'b0;
    intr_req_ptr_i         = 1'b0;
    op_load_i              = 1'b0;
    reg2dp_ew_alu_algo_i   = '0;
    reg2dp_ew_alu_bypass_i = 1'b0;
    reg2dp_ew_bypass_i     = 1'b0;
    reg2dp_op_en_i         = 1'b0;
    reg2dp_output_dst_i    = 1'b0;
    reg2dp_perf_dma_en_i   = 1'b0;
    en_mode                = 0;
    load_div               = 16;
    err_cnt                = 0;
    exp_intr               = '0;
    exp_cnt                = '0;

    // outputs idle during reset
    repeat (RESET_CYC) begin
      @(negedge autosa_core_clk);
      check_value("sdp2glb_done_intr_pd_o", '0, sdp2glb_done_intr_pd_o);
      check_value("dp2reg_wdma_stall_o", '0, dp2reg_wdma_stall_o);
    end
    autosa_core_rstn = 1'b1;

    // normal mode with in order completion
    repeat (NORM_SEGS) begin
      set_normal_cfg();
      run_random(NORM_SEG, 40, 35);
      drain();
    end

    // equal code with one bypass set is still normal mode
    reg2dp_ew_alu_algo_i   = wdma_cfg_pkg::ALU_ALGO_EQL;
    reg2dp_ew_bypass_i     = 1'b1;
    reg2dp_ew_alu_bypass_i = 1'b0;
    reg2dp_output_dst_i    = 1'b0;
    run_random(BYP_SEG, 40, 35);
    drain();
    reg2dp_ew_bypass_i     = 1'b0;
    reg2dp_ew_alu_bypass_i = 1'b1;
    run_random(BYP_SEG, 40, 35);
    drain();

    // fill up then push and pop together on a full queue
    set_normal_cfg();
    repeat (DEPTH) run_cycle(1'b1, 1'($urandom % 2), 1'b0);
    repeat (20) run_cycle(1'b1, 1'($urandom % 2), 1'b1);
    run_random(FULL_CYC, 90, 55);
    drain();

    // quiet mode from the unbypassed equal algorithm
    reg2dp_ew_bypass_i     = 1'b0;
    reg2dp_ew_alu_bypass_i = 1'b0;
    reg2dp_ew_alu_algo_i   = wdma_cfg_pkg::ALU_ALGO_EQL;
    reg2dp_output_dst_i    = 1'b0;
    run_random(QUIET_CYC, 50, 0);
    drain();

    // quiet mode from the pooling destination
    reg2dp_ew_alu_algo_i   = 2'($urandom % 4);
    reg2dp_ew_bypass_i     = 1'($urandom % 2);
    reg2dp_ew_alu_bypass_i = 1'($urandom % 2);
    reg2dp_output_dst_i    = wdma_cfg_pkg::OUTPUT_DST_PDP;
    run_random(QUIET_CYC, 50, 0);
    drain();

    // stall counter with both enables on
    set_normal_cfg();
    run_random(STALL_CYC, 20, 20);
    drain();

    // stall counter frozen with frequent op_load
    en_mode  = 1;
    load_div = 4;
    run_random(HOLD_CYC, 20, 20);
    drain();

    // last prediction
    @(negedge autosa_core_clk);
    check_value("sdp2glb_done_intr_pd_o", exp_intr, sdp2glb_done_intr_pd_o);
    check_value("dp2reg_wdma_stall_o", exp_cnt, dp2reg_wdma_stall_o);

    if (err_cnt == 0) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

// File: verif/wdma_intr_assertions.sv
`timescale 1ns/1ps

module wdma_intr_assertions (
  input logic autosa_core_clk,
  input logic autosa_core_rstn,
  input logic push_i,
  input logic pop_i,
  input logic head_vld_i,
  input logic full_i
);

  // ====================
  // queue usage rules
  // ====================

  // write completion only for a layer still in flight
  a_no_pop_empty : assert property (
    @(posedge autosa_core_clk) disable iff (!autosa_core_rstn)
    pop_i |-> head_vld_i
  ) else $error("write completion while the pending queue is empty");

  // full queue takes a push only when the head leaves at the same edge
  a_no_push_full : assert property (
    @(posedge autosa_core_clk) disable iff (!autosa_core_rstn)
    (push_i && full_i) |-> pop_i
  ) else $error("interrupt request pushed into a full pending queue");

  // ====================
  // reset state
  // ====================

  // queue comes out of reset empty
  a_empty_after_rst : assert property (
    @(posedge autosa_core_clk)
    $rose(autosa_core_rstn) |-> !head_vld_i
  ) else $error("pending queue not empty after reset");

endmodule

// attached to every queue instance
bind wdma_intr_queue wdma_intr_assertions u_queue_assertions (
  .autosa_core_clk  (autosa_core_clk),
  .autosa_core_rstn (autosa_core_rstn),
  .push_i           (push_i),
  .pop_i            (pop_i),
  .head_vld_i       (head_vld_o),
  .full_i           (full)
);

// File: hdl/wdma_intr_top.sv
`timescale 1ns/1ps

module wdma_intr_top #(
  parameter int unsigned INTR_QUEUE_DEPTH = 4
) (
  input  logic                      autosa_core_clk,
  input  logic                      autosa_core_rstn,
  // dma write side
  input  logic                      dma_wr_req_vld_i,
  input  logic                      dma_wr_req_rdy_i,
  input  logic                      dma_wr_rsp_complete_i,
  // layer done request
  input  logic                      intr_req_pvld_i,
  input  wdma_intr_pkg::intr_ptr_t  intr_req_ptr_i,
  input  logic                      op_load_i,
  // configuration registers
  input  wdma_cfg_pkg::alu_algo_t   reg2dp_ew_alu_algo_i,
  input  logic                      reg2dp_ew_alu_bypass_i,
  input  logic                      reg2dp_ew_bypass_i,
  input  logic                      reg2dp_op_en_i,
  input  logic                      reg2dp_output_dst_i,
  input  logic                      reg2dp_perf_dma_en_i,
  // status and interrupts
  output wdma_intr_pkg::stall_cnt_t dp2reg_wdma_stall_o,
  output wdma_intr_pkg::intr_vec_t  sdp2glb_done_intr_pd_o
);

  // decode to queue and interrupt stage
  logic                     queue_push;
  wdma_intr_pkg::intr_vec_t internal_intr;

  // oldest pending pointer
  wdma_intr_pkg::intr_ptr_t head_ptr;

  // ====================
  // decode
  // ====================

  wdma_cfg_decode u_cfg_decode (
    .reg2dp_ew_bypass_i     (reg2dp_ew_bypass_i),
    .reg2dp_ew_alu_bypass_i (reg2dp_ew_alu_bypass_i),
    .reg2dp_ew_alu_algo_i   (reg2dp_ew_alu_algo_i),
    .reg2dp_output_dst_i    (reg2dp_output_dst_i),
    .intr_req_pvld_i        (intr_req_pvld_i),
    .intr_req_ptr_i         (intr_req_ptr_i),
    .queue_push_o           (queue_push),
    .internal_intr_o        (internal_intr)
  );

  // ====================
  // execute
  // ====================

  // pending layers, popped as each write completes
  // head valid is only observed inside the queue instance
  wdma_intr_queue #(
    .DEPTH (INTR_QUEUE_DEPTH)
  ) u_intr_queue (
    .autosa_core_clk  (autosa_core_clk),
    .autosa_core_rstn (autosa_core_rstn),
    .push_i           (queue_push),
    .push_ptr_i       (intr_req_ptr_i),
    .pop_i            (dma_wr_rsp_complete_i),
    .head_vld_o       (),
    .head_ptr_o       (head_ptr)
  );

  wdma_stall_counter u_stall_counter (
    .autosa_core_clk  (autosa_core_clk),
    .autosa_core_rstn (autosa_core_rstn),
    .dma_wr_req_vld_i (dma_wr_req_vld_i),
    .dma_wr_req_rdy_i (dma_wr_req_rdy_i),
    .op_load_i        (op_load_i),
    .op_en_i          (reg2dp_op_en_i),
    .perf_dma_en_i    (reg2dp_perf_dma_en_i),
    .stall_cnt_o      (dp2reg_wdma_stall_o)
  );

  // ====================
  // result
  // ====================

  wdma_done_intr u_done_intr (
    .autosa_core_clk  (autosa_core_clk),
    .autosa_core_rstn (autosa_core_rstn),
    .wr_complete_i    (dma_wr_rsp_complete_i),
    .head_ptr_i       (head_ptr),
    .internal_intr_i  (internal_intr),
    .done_intr_o      (sdp2glb_done_intr_pd_o)
  );

endmodule

// File: hdl/wdma_stall_counter.sv
`timescale 1ns/1ps

module wdma_stall_counter (
  input  logic                      autosa_core_clk,
  input  logic                      autosa_core_rstn,
  input  logic                      dma_wr_req_vld_i,
  input  logic                      dma_wr_req_rdy_i,
  input  logic                      op_load_i,
  input  logic                      op_en_i,
  input  logic                      perf_dma_en_i,
  output wdma_intr_pkg::stall_cnt_t stall_cnt_o
);

  logic                      cnt_en;
  logic                      cnt_inc;
  wdma_intr_pkg::stall_cnt_t cnt_cur;
  wdma_intr_pkg::stall_cnt_t cnt_nxt;

  // ====================
  // control
  // ====================

  // request waiting on the dma, one stall cycle
  assign cnt_inc = dma_wr_req_vld_i & !dma_wr_req_rdy_i;

  // counter frozen unless the layer and perf stats are both on
  assign cnt_en = op_en_i & perf_dma_en_i;

  // op_load restarts the count, wins over increment
  // natural wrap at full width
  assign cnt_nxt = op_load_i ? '0 : cnt_cur + cnt_inc;

  // ====================
  // count register
  // ====================

  always_ff @(posedge autosa_core_clk or negedge autosa_core_rstn) begin
    if (!autosa_core_rstn) begin
      cnt_cur <= '0;
    end else if (cnt_en) begin
      cnt_cur <= cnt_nxt;
    end
  end

  assign stall_cnt_o = cnt_cur;

endmodule

// File: hdl/wdma_done_intr.sv
`timescale 1ns/1ps

module wdma_done_intr (
  input  logic                     autosa_core_clk,
  input  logic                     autosa_core_rstn,
  input  logic                     wr_complete_i,
  input  wdma_intr_pkg::intr_ptr_t head_ptr_i,
  input  wdma_intr_pkg::intr_vec_t internal_intr_i,
  output wdma_intr_pkg::intr_vec_t done_intr_o
);

  // completion decoded against the oldest pending layer
  wdma_intr_pkg::intr_vec_t wr_intr;

  // both interrupt sources merged before the flops
  wdma_intr_pkg::intr_vec_t intr_nxt;

  // ====================
  // write completion
  // ====================

  always_comb begin
    wr_intr = '0;
    if (wr_complete_i) begin
      wr_intr[head_ptr_i] = 1'b1;
    end
  end

  // quiet and normal paths never fire for the same layer
  assign intr_nxt = wr_intr | internal_intr_i;

  // ====================
  // output pulses
  // ====================

  // one flop per interrupt line, single cycle pulse
  for (genvar i = 0; i < wdma_intr_pkg::NUM_INTR; i++) begin : g_intr
    always_ff @(posedge autosa_core_clk or negedge autosa_core_rstn) begin
      if (!autosa_core_rstn) begin
        done_intr_o[i] <= 1'b0;
      end else begin
        done_intr_o[i] <= intr_nxt[i];
      end
    end
  end

endmodule

// File: hdl/wdma_intr_queue.sv
`timescale 1ns/1ps

module wdma_intr_queue #(
  parameter int unsigned DEPTH = 4
) (
  input  logic                     autosa_core_clk,
  input  logic                     autosa_core_rstn,
  input  logic                     push_i,
  input  wdma_intr_pkg::intr_ptr_t push_ptr_i,
  input  logic                     pop_i,
  output logic                     head_vld_o,
  output wdma_intr_pkg::intr_ptr_t head_ptr_o
);

  // index and occupancy widths
  localparam int unsigned IDX_W = $clog2(DEPTH);
  localparam int unsigned CNT_W = $clog2(DEPTH + 1);

  localparam logic [IDX_W-1:0] LAST_IDX = IDX_W'(DEPTH - 1);
  localparam logic [CNT_W-1:0] FULL_CNT = CNT_W'(DEPTH);

  // pointer storage, one slot per layer in flight
  wdma_intr_pkg::intr_ptr_t ptr_mem [DEPTH];

  logic [IDX_W-1:0] wr_idx;
  logic [IDX_W-1:0] rd_idx;
  logic [CNT_W-1:0] count;

  logic empty;
  logic full;
  logic do_push;
  logic do_pop;

  // ====================
  // status
  // ====================

  assign empty = (count == '0);
  assign full  = (count == FULL_CNT);

  // pop only a real entry
  assign do_pop = pop_i & !empty;

  // full queue still takes a push when the head leaves at the same edge
  assign do_push = push_i & (!full | do_pop);

  // ====================
  // storage
  // ====================

  always_ff @(posedge autosa_core_clk) begin
    if (do_push) begin
      ptr_mem[wr_idx] <= push_ptr_i;
    end
  end

  // ====================
  // indices and count
  // ====================

  always_ff @(posedge autosa_core_clk or negedge autosa_core_rstn) begin
    if (!autosa_core_rstn) begin
      wr_idx <= '0;
      rd_idx <= '0;
      count  <= '0;
    end else begin
      // wrap by compare, depth need not be a power of two
      if (do_push) begin
        wr_idx <= (wr_idx == LAST_IDX) ? '0 : wr_idx + 1'b1;
      end
      if (do_pop) begin
        rd_idx <= (rd_idx == LAST_IDX) ? '0 : rd_idx + 1'b1;
      end
      // simultaneous push and pop leaves count as is
      if (do_push && !do_pop) begin
        count <= count + 1'b1;
      end else if (do_pop && !do_push) begin
        count <= count - 1'b1;
      end
    end
  end

  // ====================
  // head of queue
  // ====================

  // oldest layer still being written
  assign head_vld_o = !empty;
  assign head_ptr_o = ptr_mem[rd_idx];

endmodule

// File: hdl/wdma_cfg_decode.sv
`timescale 1ns/1ps

module wdma_cfg_decode (
  input  logic                    reg2dp_ew_bypass_i,
  input  logic                    reg2dp_ew_alu_bypass_i,
  input  wdma_cfg_pkg::alu_algo_t reg2dp_ew_alu_algo_i,
  input  logic                    reg2dp_output_dst_i,
  input  logic                    intr_req_pvld_i,
  input  wdma_intr_pkg::intr_ptr_t intr_req_ptr_i,
  output logic                    queue_push_o,
  output wdma_intr_pkg::intr_vec_t internal_intr_o
);

  logic mode_eql;
  logic mode_pdp;
  logic mode_quiet;

  // ====================
  // mode decode
  // ====================

  // equal algorithm only counts when both bypasses are off
  assign mode_eql = !reg2dp_ew_bypass_i
                  & !reg2dp_ew_alu_bypass_i
                  & (reg2dp_ew_alu_algo_i == wdma_cfg_pkg::ALU_ALGO_EQL);

  // pooling engine consumes the output, no memory write to wait for
  assign mode_pdp = (reg2dp_output_dst_i == wdma_cfg_pkg::OUTPUT_DST_PDP);

  // either case: nothing gets written back by this dma
  assign mode_quiet = mode_eql | mode_pdp;

  // ====================
  // request routing
  // ====================

  // normal mode, park the pointer until write completion
  assign queue_push_o = intr_req_pvld_i & !mode_quiet;

  // quiet mode, raise the interrupt straight away
  always_comb begin
    internal_intr_o = '0;
    if (intr_req_pvld_i && mode_quiet) begin
      internal_intr_o[intr_req_ptr_i] = 1'b1;
    end
  end

endmodule

// File: hdl/wdma_intr_pkg.sv
package wdma_intr_pkg;

  // ====================
  // interrupt encoding
  // ====================

  // ping-pong layer pointer carried by each done request
  typedef logic intr_ptr_t;

  // one done interrupt per pointer value
  localparam int unsigned NUM_INTR = 2;

  // bit i set means layer with pointer i is done
  typedef logic [NUM_INTR-1:0] intr_vec_t;

  // ====================
  // perf statistics
  // ====================

  // stall counter width, matches the status register
  localparam int unsigned STALL_CNT_W = 32;

  typedef logic [STALL_CNT_W-1:0] stall_cnt_t;

endpackage

// File: hdl/wdma_cfg_pkg.sv
package wdma_cfg_pkg;

  // ====================
  // register field widths
  // ====================

  // element-wise alu algorithm select
  localparam int unsigned ALU_ALGO_W = 2;

  // output destination select, single bit
  localparam int unsigned OUTPUT_DST_W = 1;

  typedef logic [ALU_ALGO_W-1:0] alu_algo_t;

  // ====================
  // field encodings
  // ====================

  // equal compare, no real data written by the ew stage
  localparam alu_algo_t ALU_ALGO_EQL = alu_algo_t'(3);

  // result routed on to the pooling engine
  localparam logic [OUTPUT_DST_W-1:0] OUTPUT_DST_PDP = 1'b1;

endpackage
